// ==== include/aes_macros.svh ====
`ifndef AES_MACROS_SVH
`define AES_MACROS_SVH

// block and key width
`define AES_BLOCK_BITS 128

// AES-128 round count
`define AES_ROUNDS 10

// round keys 0 to 10
`define AES_KEY_ENTRIES 11

// x^8 + x^4 + x^3 + x + 1 with the top bit dropped
`define AES_GF_POLY 8'h1b

// added after the affine map of the s-box
`define AES_SBOX_AFFINE 8'h63

`endif

// ==== rtl/aes_pkg.sv ====
`include "aes_macros.svh"

package aes_pkg;

    typedef logic [7:0] aes_byte_t;
    typedef logic [31:0] aes_word_t;
    typedef logic [`AES_BLOCK_BITS-1:0] aes_block_t;
    typedef logic [3:0] aes_key_idx_t;

    // byte 0 is the most significant, column c holds bytes 4c to 4c+3
    typedef union packed {
        aes_byte_t [0:15] bytes;
        aes_word_t [0:3]  cols;
    } aes_state_t;

    // mixcolumns matrix rows, first row only, others are rotations
    localparam aes_word_t MIX_FWD = 32'h02030101;
    localparam aes_word_t MIX_INV = 32'h0e0b0d09;

    function automatic aes_byte_t xtime(aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? `AES_GF_POLY : 8'h00);
    endfunction

    function automatic aes_byte_t gf_mul(aes_byte_t a, aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t p;
        acc = 8'h00;
        p = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i])
                acc = acc ^ p;
            p = xtime(p);
        end
        return acc;
    endfunction

    // a^254, maps 0 to 0 as the s-box wants
    function automatic aes_byte_t gf_inv(aes_byte_t a);
        aes_byte_t r;
        aes_byte_t p;
        r = 8'h01;
        p = a;
        for (int i = 0; i < 7; i++) begin
            p = gf_mul(p, p);
            r = gf_mul(r, p);
        end
        return r;
    endfunction

    function automatic aes_byte_t rotl8(aes_byte_t b, int unsigned n);
        return (b << n) | (b >> (8 - n));
    endfunction

    function automatic aes_byte_t sub_byte(aes_byte_t b);
        aes_byte_t x;
        x = gf_inv(b);
        return x ^ rotl8(x, 1) ^ rotl8(x, 2) ^ rotl8(x, 3) ^ rotl8(x, 4) ^ `AES_SBOX_AFFINE;
    endfunction

    // undo the affine map first, then invert in the field
    function automatic aes_byte_t inv_sub_byte(aes_byte_t b);
        aes_byte_t y;
        y = b ^ `AES_SBOX_AFFINE;
        return gf_inv(rotl8(y, 1) ^ rotl8(y, 3) ^ rotl8(y, 6));
    endfunction

    function automatic aes_word_t sub_word(aes_word_t w);
        return {sub_byte(w[31:24]), sub_byte(w[23:16]), sub_byte(w[15:8]), sub_byte(w[7:0])};
    endfunction

    function automatic aes_word_t rot_word(aes_word_t w);
        return {w[23:0], w[31:24]};
    endfunction

    function automatic aes_state_t sub_bytes(aes_state_t s);
        aes_state_t o;
        for (int i = 0; i < 16; i++)
            o.bytes[i] = sub_byte(s.bytes[i]);
        return o;
    endfunction

    function automatic aes_state_t inv_sub_bytes(aes_state_t s);
        aes_state_t o;
        for (int i = 0; i < 16; i++)
            o.bytes[i] = inv_sub_byte(s.bytes[i]);
        return o;
    endfunction

    // row r moves left by r columns
    function automatic aes_state_t shift_rows(aes_state_t s);
        aes_state_t o;
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                o.bytes[4*c+r] = s.bytes[4*((c+r)%4)+r];
        return o;
    endfunction

    function automatic aes_state_t inv_shift_rows(aes_state_t s);
        aes_state_t o;
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                o.bytes[4*((c+r)%4)+r] = s.bytes[4*c+r];
        return o;
    endfunction

    // one column times a circulant matrix given by its first row
    function automatic aes_word_t mix_word(aes_word_t w, aes_word_t coef);
        aes_word_t o;
        o = '0;
        for (int i = 0; i < 4; i++)
            for (int j = 0; j < 4; j++)
                o[31-8*i -: 8] = o[31-8*i -: 8]
                                 ^ gf_mul(w[31-8*j -: 8], coef[31-8*((j-i+4)%4) -: 8]);
        return o;
    endfunction

    function automatic aes_state_t mix_columns(aes_state_t s);
        aes_state_t o;
        for (int c = 0; c < 4; c++)
            o.cols[c] = mix_word(s.cols[c], MIX_FWD);
        return o;
    endfunction

    function automatic aes_state_t inv_mix_columns(aes_state_t s);
        aes_state_t o;
        for (int c = 0; c < 4; c++)
            o.cols[c] = mix_word(s.cols[c], MIX_INV);
        return o;
    endfunction

endpackage

// ==== rtl/aes_key_schedule.sv ====
`timescale 1ns/100ps
`include "aes_macros.svh"

module aes_key_schedule
    import aes_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  aes_block_t   key,
    output logic         key_we,
    output aes_key_idx_t key_wr_idx,
    output aes_block_t   key_wr_data,
    output logic         done
);

    localparam aes_key_idx_t LAST = aes_key_idx_t'(`AES_ROUNDS);

    aes_state_t   prev_key;
    aes_byte_t    rcon;
    aes_key_idx_t cnt;
    logic         busy;
    aes_word_t    g_word;
    aes_word_t    n0;
    aes_word_t    n1;
    aes_word_t    n2;
    aes_word_t    n3;

    // g() on the last word of the previous key
    assign g_word = sub_word(rot_word(prev_key.cols[3])) ^ {rcon, 24'h000000};

    assign n0 = prev_key.cols[0] ^ g_word;
    assign n1 = prev_key.cols[1] ^ n0;
    assign n2 = prev_key.cols[2] ^ n1;
    assign n3 = prev_key.cols[3] ^ n2;

    // key 0 goes straight through on the start cycle
    assign key_we      = start | busy;
    assign key_wr_idx  = start ? aes_key_idx_t'(0) : cnt;
    assign key_wr_data = start ? key : {n0, n1, n2, n3};
    assign done        = busy && (cnt == LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= aes_key_idx_t'(1);
        end else if (busy) begin
            busy <= !done;
            cnt  <= cnt + aes_key_idx_t'(1);
        end
    end

    // rcon doubles in the field each round
    always_ff @(posedge clk) begin
        if (start) begin
            prev_key <= key;
            rcon     <= 8'h01;
        end else if (busy) begin
            prev_key <= {n0, n1, n2, n3};
            rcon     <= xtime(rcon);
        end
    end

endmodule

// ==== rtl/aes_round_key_store.sv ====
`timescale 1ns/100ps
`include "aes_macros.svh"

module aes_round_key_store
    import aes_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         key_we,
    input  aes_key_idx_t key_wr_idx,
    input  aes_block_t   key_wr_data,
    input  aes_key_idx_t key_rd_idx,
    output aes_block_t   key_rd_data
);

    aes_block_t                  keys [`AES_KEY_ENTRIES];
    logic [`AES_KEY_ENTRIES-1:0] valid;
    logic                        wr_ok;

    assign wr_ok = key_we && (key_wr_idx < `AES_KEY_ENTRIES);

    always_ff @(posedge clk) begin
        if (wr_ok)
            keys[key_wr_idx] <= key_wr_data;
    end

    always_ff @(posedge clk) begin
        if (rst)
            valid <= '0;
        else if (wr_ok)
            valid[key_wr_idx] <= 1'b1;
    end

    // unwritten or out of range entries read as zero
    always_comb begin
        key_rd_data = '0;
        if (key_rd_idx < `AES_KEY_ENTRIES) begin
            if (valid[key_rd_idx])
                key_rd_data = keys[key_rd_idx];
        end
    end

endmodule

// ==== rtl/aes_round_engine.sv ====
`timescale 1ns/100ps
`include "aes_macros.svh"

module aes_round_engine
    import aes_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         decrypt,
    input  aes_block_t   block_in,
    output aes_key_idx_t key_rd_idx,
    input  aes_block_t   key_rd_data,
    output logic         done,
    output aes_block_t   block_out
);

    localparam aes_key_idx_t LAST = aes_key_idx_t'(`AES_ROUNDS);

    aes_state_t   state;
    aes_key_idx_t rnd;
    logic         busy;
    logic         last_round;
    aes_state_t   enc_sr;
    aes_state_t   enc_next;
    aes_state_t   dec_ark;
    aes_state_t   dec_next;

    assign last_round = (rnd == LAST);

    // decryption walks the key store from the top down
    always_comb begin
        if (start)
            key_rd_idx = decrypt ? LAST : aes_key_idx_t'(0);
        else
            key_rd_idx = decrypt ? LAST - rnd : rnd;
    end

    // forward round
    always_comb begin
        enc_sr = shift_rows(sub_bytes(state));
        if (last_round)
            enc_next = enc_sr ^ key_rd_data;
        else
            enc_next = mix_columns(enc_sr) ^ key_rd_data;
    end

    // inverse round, key added ahead of InvMixColumns
    always_comb begin
        dec_ark = inv_sub_bytes(inv_shift_rows(state)) ^ key_rd_data;
        if (last_round)
            dec_next = dec_ark;
        else
            dec_next = inv_mix_columns(dec_ark);
    end

    always_ff @(posedge clk) begin
        if (start)
            state <= block_in ^ key_rd_data;
        else if (busy)
            state <= decrypt ? dec_next : enc_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            rnd  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                rnd  <= aes_key_idx_t'(1);
            end else if (busy) begin
                rnd <= rnd + aes_key_idx_t'(1);
                if (last_round) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    assign block_out = state;

endmodule

// ==== rtl/aes_core.sv ====
`timescale 1ns/100ps

module aes_core
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req,
    input  logic       decrypt,
    input  aes_block_t key_in,
    input  aes_block_t data_in,
    output logic       ack,
    output aes_block_t data_out
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_EXPAND = 2'd1;
    localparam logic [1:0] ST_ROUNDS = 2'd2;
    localparam logic [1:0] ST_HOLD   = 2'd3;

    logic [1:0]   st;
    logic         accept;
    logic         mode_lat;
    aes_block_t   key_lat;
    aes_block_t   data_lat;
    logic         expand_start;
    logic         expand_done;
    logic         round_start;
    logic         round_done;
    logic         key_we;
    aes_key_idx_t key_wr_idx;
    aes_block_t   key_wr_data;
    aes_key_idx_t key_rd_idx;
    aes_block_t   key_rd_data;
    aes_block_t   block_out;

    assign accept = (st == ST_IDLE) && req && !ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            st           <= ST_IDLE;
            ack          <= 1'b0;
            mode_lat     <= 1'b0;
            expand_start <= 1'b0;
            round_start  <= 1'b0;
            data_out     <= '0;
        end else begin
            expand_start <= 1'b0;
            round_start  <= 1'b0;
            case (st)
                ST_IDLE: begin
                    if (accept) begin
                        mode_lat     <= decrypt;
                        expand_start <= 1'b1;
                        st           <= ST_EXPAND;
                    end
                end
                ST_EXPAND: begin
                    if (expand_done) begin
                        round_start <= 1'b1;
                        st          <= ST_ROUNDS;
                    end
                end
                ST_ROUNDS: begin
                    if (round_done) begin
                        data_out <= block_out;
                        ack      <= 1'b1;
                        st       <= ST_HOLD;
                    end
                end
                default: begin
                    // result waits here until the source lets go of req
                    if (!req) begin
                        ack <= 1'b0;
                        st  <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            key_lat  <= key_in;
            data_lat <= data_in;
        end
    end

    aes_key_schedule u_key_schedule (
        .clk         (clk),
        .rst         (rst),
        .start       (expand_start),
        .key         (key_lat),
        .key_we      (key_we),
        .key_wr_idx  (key_wr_idx),
        .key_wr_data (key_wr_data),
        .done        (expand_done)
    );

    aes_round_key_store u_key_store (
        .clk         (clk),
        .rst         (rst),
        .key_we      (key_we),
        .key_wr_idx  (key_wr_idx),
        .key_wr_data (key_wr_data),
        .key_rd_idx  (key_rd_idx),
        .key_rd_data (key_rd_data)
    );

    aes_round_engine u_round_engine (
        .clk         (clk),
        .rst         (rst),
        .start       (round_start),
        .decrypt     (mode_lat),
        .block_in    (data_lat),
        .key_rd_idx  (key_rd_idx),
        .key_rd_data (key_rd_data),
        .done        (round_done),
        .block_out   (block_out)
    );

endmodule

// ==== include/tb_aes_ref_model.svh ====
`ifndef TB_AES_REF_MODEL_SVH
`define TB_AES_REF_MODEL_SVH

// s-box tables, filled by walking the field with generator 3
logic [7:0] sbox_tab [256];
logic [7:0] inv_sbox_tab [256];

function automatic logic [7:0] times2(logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
endfunction

// p runs over all nonzero bytes, q tracks its inverse
task automatic build_sbox_tables();
    logic [7:0] p;
    logic [7:0] q;
    logic [7:0] x;
    p = 8'h01;
    q = 8'h01;
    sbox_tab[0] = 8'h63;
    repeat (255) begin
        p = p ^ times2(p);
        q = q ^ (q << 1);
        q = q ^ (q << 2);
        q = q ^ (q << 4);
        if (q[7])
            q = q ^ 8'h09;
        x = q ^ {q[6:0], q[7]} ^ {q[5:0], q[7:6]} ^ {q[4:0], q[7:5]} ^ {q[3:0], q[7:4]};
        sbox_tab[p] = x ^ 8'h63;
    end
    for (int i = 0; i < 256; i++)
        inv_sbox_tab[sbox_tab[i]] = i[7:0];
endtask

// key n of the schedule, recomputed from the cipher key
function automatic logic [127:0] round_key(logic [127:0] key, int n);
    logic [31:0] w0, w1, w2, w3, t;
    logic [7:0] rc;
    {w0, w1, w2, w3} = key;
    rc = 8'h01;
    for (int r = 0; r < n; r++) begin
        t = {sbox_tab[w3[23:16]], sbox_tab[w3[15:8]], sbox_tab[w3[7:0]], sbox_tab[w3[31:24]]};
        t[31:24] = t[31:24] ^ rc;
        w0 = w0 ^ t;
        w1 = w1 ^ w0;
        w2 = w2 ^ w1;
        w3 = w3 ^ w2;
        rc = times2(rc);
    end
    return {w0, w1, w2, w3};
endfunction

function automatic logic [31:0] mix_column(logic [31:0] w);
    logic [7:0] all;
    logic [31:0] o;
    all = w[31:24] ^ w[23:16] ^ w[15:8] ^ w[7:0];
    for (int i = 0; i < 4; i++)
        o[31-8*i -: 8] = w[31-8*i -: 8] ^ all
                         ^ times2(w[31-8*i -: 8] ^ w[31-8*((i+1)%4) -: 8]);
    return o;
endfunction

// inverse mix as a pre-step followed by the forward mix
function automatic logic [31:0] unmix_column(logic [31:0] w);
    logic [7:0] u;
    logic [7:0] v;
    u = times2(times2(w[31:24] ^ w[15:8]));
    v = times2(times2(w[23:16] ^ w[7:0]));
    return mix_column(w ^ {u, v, u, v});
endfunction

// byte substitution and row shift together, they commute
function automatic logic [127:0] sub_shift(logic [127:0] v, logic inverse);
    logic [127:0] o;
    int src;
    for (int c = 0; c < 4; c++)
        for (int r = 0; r < 4; r++) begin
            src = inverse ? 4*((c-r+4)%4)+r : 4*((c+r)%4)+r;
            o[127-8*(4*c+r) -: 8] = inverse ? inv_sbox_tab[v[127-8*src -: 8]]
                                            : sbox_tab[v[127-8*src -: 8]];
        end
    return o;
endfunction

function automatic logic [127:0] cipher(logic [127:0] key, logic [127:0] pt);
    logic [127:0] v;
    v = pt ^ key;
    for (int rnd = 1; rnd <= 10; rnd++) begin
        v = sub_shift(v, 1'b0);
        if (rnd != 10)
            v = {mix_column(v[127:96]), mix_column(v[95:64]),
                 mix_column(v[63:32]), mix_column(v[31:0])};
        v = v ^ round_key(key, rnd);
    end
    return v;
endfunction

function automatic logic [127:0] inv_cipher(logic [127:0] key, logic [127:0] ct);
    logic [127:0] v;
    v = ct ^ round_key(key, 10);
    for (int rnd = 9; rnd >= 0; rnd--) begin
        v = sub_shift(v, 1'b1) ^ round_key(key, rnd);
        if (rnd != 0)
            v = {unmix_column(v[127:96]), unmix_column(v[95:64]),
                 unmix_column(v[63:32]), unmix_column(v[31:0])};
    end
    return v;
endfunction

`endif

// ==== testbench/tb_aes_core.sv ====
`timescale 1ns/100ps

module tb_aes_core
    import aes_pkg::*;
();

    localparam int NUM_RANDOM = 40;
    localparam int NUM_TRANS = 2 + 3 * NUM_RANDOM;
    localparam int MAX_HOLD = 15;
    localparam int LATENCY = 23;
    localparam int WATCHDOG_CYCLES = NUM_TRANS * (LATENCY + MAX_HOLD + 4) + 100;

    logic       clk;
    logic       rst;
    logic       req;
    logic       decrypt;
    aes_block_t key_in;
    aes_block_t data_in;
    logic       ack;
    aes_block_t data_out;

    int errors;
    int tests;
    int failed_tests;

    `include "tb_aes_ref_model.svh"

    aes_core dut0 (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .decrypt  (decrypt),
        .key_in   (key_in),
        .data_in  (data_in),
        .ack      (ack),
        .data_out (data_out)
    );

    always #20 clk = ~clk;

    task automatic check_block(input string name, input aes_block_t got, input aes_block_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("ERR ack_latency got %h expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic aes_block_t random_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic report_test(input string label, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %0d %s ok", tests, label);
        end else begin
            failed_tests++;
            $display("test %0d %s failed", tests, label);
        end
    endtask

    // one four-phase transfer with a random hold of req after ack
    task automatic run_transaction(input aes_block_t key, input aes_block_t data,
                                   input logic dec, output aes_block_t result);
        int cycles;
        int hold;
        aes_block_t held;
        hold = $urandom % (MAX_HOLD + 1);
        cycles = 0;
        @(posedge clk);
        req     <= 1'b1;
        decrypt <= dec;
        key_in  <= key;
        data_in <= data;
        // accepting edge, inputs change while the core is busy
        @(posedge clk);
        decrypt <= ~dec;
        key_in  <= random_block();
        data_in <= random_block();
        @(negedge clk);
        while (!ack) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        check_latency(cycles, LATENCY);
        held = data_out;
        repeat (hold) begin
            @(posedge clk);
            @(negedge clk);
            check_flag("ack", ack, 1'b1);
            check_block("data_out", data_out, held);
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_flag("ack", ack, 1'b1);
        @(posedge clk);
        @(negedge clk);
        check_flag("ack", ack, 1'b0);
        result = held;
    endtask

    initial begin
        aes_block_t key;
        aes_block_t pt;
        aes_block_t ct;
        aes_block_t got;
        aes_block_t back;
        int mark;
        int first_draw;
        first_draw = $urandom(27);
        clk = 1'b0;
        rst = 1'b1;
        req = 1'b0;
        decrypt = 1'b0;
        key_in = '0;
        data_in = '0;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        build_sbox_tables();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        mark = errors;
        repeat (4) begin
            @(negedge clk);
            check_flag("ack", ack, 1'b0);
            check_block("data_out", data_out, '0);
        end
        report_test("idle after reset", mark);

        // FIPS-197 appendix C.1
        key = 128'h000102030405060708090a0b0c0d0e0f;
        pt  = 128'h00112233445566778899aabbccddeeff;
        ct  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        mark = errors;
        check_block("model_ciphertext", cipher(key, pt), ct);
        run_transaction(key, pt, 1'b0, got);
        check_block("data_out", got, ct);
        report_test("known answer encrypt", mark);
        mark = errors;
        run_transaction(key, ct, 1'b1, got);
        check_block("data_out", got, pt);
        report_test("known answer decrypt", mark);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            key = random_block();
            pt = random_block();
            mark = errors;
            run_transaction(key, pt, 1'b0, got);
            check_block("data_out", got, cipher(key, pt));
            report_test("random encrypt", mark);
            mark = errors;
            run_transaction(key, got, 1'b1, back);
            check_block("data_out", back, pt);
            report_test("round trip decrypt", mark);
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            key = random_block();
            ct = random_block();
            mark = errors;
            run_transaction(key, ct, 1'b1, got);
            check_block("data_out", got, inv_cipher(key, ct));
            report_test("random decrypt", mark);
        end

        $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
rtl/aes_pkg.sv
rtl/aes_key_schedule.sv
rtl/aes_round_key_store.sv
rtl/aes_round_engine.sv
rtl/aes_core.sv
testbench/tb_aes_core.sv

// ==== Bender.yml ====
package:
  name: aes_core

export_include_dirs:
  - include

sources:
  - rtl/aes_pkg.sv
  - rtl/aes_key_schedule.sv
  - rtl/aes_round_key_store.sv
  - rtl/aes_round_engine.sv
  - rtl/aes_core.sv
  - target: test
    files:
      - testbench/tb_aes_core.sv
